/* rtl/tconv_params.svh */
// Accumulation back end parameters

`ifndef TCONV_PARAMS_SVH
`define TCONV_PARAMS_SVH

// width of one ternary product and of every partial sum
`define TCONV_FEATURE_WIDTH 16

// side of the convolution window, 5x5 products per kernel
`define TCONV_KERNEL_SIZE 5

// kernels (channels) carried by one beat
`define TCONV_TN 4

`define TCONV_SCALER_WIDTH 16

// downstream buffer slots
`define TCONV_CREDITS 4

`endif

/* rtl/tconv_pkg.sv */
// Accumulation back end types

`include "tconv_params.svh"

package tconv_pkg;

    // one product or one wrapped sum
    typedef logic [`TCONV_FEATURE_WIDTH-1:0] feature_t;

    typedef logic [`TCONV_SCALER_WIDTH-1:0] scaler_t;

    // full unsigned product of sum and scaler
    typedef logic [`TCONV_FEATURE_WIDTH+`TCONV_SCALER_WIDTH-1:0] scaled_t;

    // one enable bit per channel
    typedef logic [`TCONV_TN-1:0] chan_mask_t;

    // holds 0 up to the credit limit
    typedef logic [$clog2(`TCONV_CREDITS+1)-1:0] credit_cnt_t;

    typedef logic [0:0] cfg_addr_t;

    // register map
    localparam cfg_addr_t CFG_ADDR_SCALER = 1'b0;
    localparam cfg_addr_t CFG_ADDR_MASK   = 1'b1;

endpackage

/* rtl/kernel_adder_tree.sv */
// Pipelined kernel adder tree

`timescale 1ns/1ps

`include "tconv_params.svh"

module kernel_adder_tree
    import tconv_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_valid,
    input  feature_t [`TCONV_KERNEL_SIZE*`TCONV_KERNEL_SIZE-1:0] i_terms,
    output feature_t o_sum,
    output logic o_valid
);

    localparam int N_TERMS    = `TCONV_KERNEL_SIZE * `TCONV_KERNEL_SIZE;
    localparam int N_PAIRS    = N_TERMS / 2;
    localparam int N_S1       = N_PAIRS + 1;
    localparam int N_S2       = 8;
    localparam int N_S3       = 4;
    localparam int TREE_DEPTH = 4;

    feature_t [N_S1-1:0]   s1_q;
    feature_t [2*N_S2-1:0] s1_pad;
    feature_t [N_S2-1:0]   s2_q;
    feature_t [N_S3-1:0]   s3_q;
    feature_t              sum_q;
    logic [TREE_DEPTH-1:0] vld_q;

    // stage one: 12 pairs, odd product rides along
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_PAIRS; i++) begin
            s1_q[i] <= i_terms[i] + i_terms[i + N_PAIRS];
        end
        s1_q[N_PAIRS] <= i_terms[N_TERMS-1];
    end

    // pad 13 values up to 16 with zeros
    always_comb begin
        s1_pad = '0;
        for (int i = 0; i < N_S1; i++) begin
            s1_pad[i] = s1_q[i];
        end
    end

    // stage two: 16 -> 8
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_S2; i++) begin
            s2_q[i] <= s1_pad[i] + s1_pad[i + N_S2];
        end
    end

    // stage three: 8 -> 4
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_S3; i++) begin
            s3_q[i] <= s2_q[i] + s2_q[i + N_S3];
        end
    end

    // stage four: last four values in one adder
    always_ff @(posedge clk) begin
        sum_q <= s3_q[0] + s3_q[1] + s3_q[2] + s3_q[3];
    end

    // valid follows the data, one bit per stage
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[TREE_DEPTH-2:0], i_valid};
        end
    end

    assign o_sum   = sum_q;
    assign o_valid = vld_q[TREE_DEPTH-1];

endmodule

/* rtl/channel_scale_stage.sv */
// Channel sum and scaler multiply

`timescale 1ns/1ps

module channel_scale_stage
    import tconv_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_valid,
    input  feature_t [$bits(chan_mask_t)-1:0] i_sums,
    input  chan_mask_t i_mask,
    input  scaler_t i_scaler,
    output logic o_valid,
    output scaled_t o_result
);

    localparam int TN = $bits(chan_mask_t);

    feature_t masked_sum;
    feature_t total_q;
    logic     vld_q;

    // disabled channels add nothing, sum wraps at 16 bits
    always_comb begin
        masked_sum = '0;
        for (int c = 0; c < TN; c++) begin
            if (i_mask[c]) begin
                masked_sum = masked_sum + i_sums[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        total_q <= masked_sum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q   <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            vld_q   <= i_valid;
            o_valid <= vld_q;
        end
    end

    // result reads zero between beats
    always_ff @(posedge clk) begin
        if (rst || !vld_q) begin
            o_result <= '0;
        end else begin
            o_result <= scaled_t'(total_q) * scaled_t'(i_scaler);
        end
    end

endmodule

/* rtl/tconv_cfg_regs.sv */
// Scaler and channel mask registers

`timescale 1ns/1ps

module tconv_cfg_regs
    import tconv_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_cfg_we,
    input  cfg_addr_t i_cfg_addr,
    input  scaler_t i_cfg_wdata,
    output scaler_t o_cfg_rdata,
    output scaler_t o_scaler,
    output chan_mask_t o_mask
);

    scaler_t    scaler_q;
    chan_mask_t mask_q;

    // unity scale, all channels on after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            scaler_q <= scaler_t'(1);
            mask_q   <= '1;
        end else if (i_cfg_we) begin
            case (i_cfg_addr)
                CFG_ADDR_SCALER: scaler_q <= i_cfg_wdata;
                CFG_ADDR_MASK:   mask_q   <= i_cfg_wdata[$bits(chan_mask_t)-1:0];
            endcase
        end
    end

    // read-back is combinational on the address
    always_comb begin
        if (i_cfg_addr == CFG_ADDR_SCALER) begin
            o_cfg_rdata = scaler_q;
        end else begin
            o_cfg_rdata = scaler_t'(mask_q);
        end
    end

    assign o_scaler = scaler_q;
    assign o_mask   = mask_q;

endmodule

/* rtl/tconv_credit_ctrl.sv */
// Output credit counter

`timescale 1ns/1ps

`include "tconv_params.svh"

module tconv_credit_ctrl
    import tconv_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_valid,
    input  logic i_credit_return,
    output logic o_ready,
    output logic o_accept,
    output credit_cnt_t o_credits
);

    credit_cnt_t credits_q;

    // each beat reserves one downstream slot before it enters the trees
    assign o_ready  = (credits_q != '0);
    assign o_accept = i_valid && o_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits_q <= credit_cnt_t'(`TCONV_CREDITS);
        end else begin
            case ({o_accept, i_credit_return})
                2'b10: begin
                    credits_q <= credits_q - credit_cnt_t'(1);
                end
                2'b01: begin
                    credits_q <= credits_q + credit_cnt_t'(1);
                end
                // take and return together leave the count as is
                default: begin
                    credits_q <= credits_q;
                end
            endcase
        end
    end

    assign o_credits = credits_q;

endmodule

/* rtl/tconv_accum_top.sv */
// Convolution accumulation top level

`timescale 1ns/1ps

`include "tconv_params.svh"

module tconv_accum_top
    import tconv_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_valid,
    input  logic [`TCONV_TN*`TCONV_KERNEL_SIZE*`TCONV_KERNEL_SIZE*`TCONV_FEATURE_WIDTH-1:0] i_terms,
    output logic o_ready,
    input  logic i_credit_return,
    output logic o_valid,
    output scaled_t o_result,
    input  logic i_cfg_we,
    input  cfg_addr_t i_cfg_addr,
    input  scaler_t i_cfg_wdata,
    output scaler_t o_cfg_rdata
);

    localparam int KERNEL_BITS =
        `TCONV_KERNEL_SIZE * `TCONV_KERNEL_SIZE * `TCONV_FEATURE_WIDTH;

    logic                      accept;
    scaler_t                   scaler;
    chan_mask_t                mask;
    feature_t [`TCONV_TN-1:0]  kernel_sums;
    logic [`TCONV_TN-1:0]      tree_valid;

    tconv_credit_ctrl u_credit (
        .clk             (clk),
        .rst             (rst),
        .i_valid         (i_valid),
        .i_credit_return (i_credit_return),
        .o_ready         (o_ready),
        .o_accept        (accept),
        .o_credits       ()
    );

    // one tree per kernel, all launched by the same accept pulse
    for (genvar g = 0; g < `TCONV_TN; g++) begin : g_tree
        kernel_adder_tree u_tree (
            .clk     (clk),
            .rst     (rst),
            .i_valid (accept),
            .i_terms (i_terms[g*KERNEL_BITS +: KERNEL_BITS]),
            .o_sum   (kernel_sums[g]),
            .o_valid (tree_valid[g])
        );
    end

    // trees run in lockstep so their valids agree
    channel_scale_stage u_scale (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (&tree_valid),
        .i_sums   (kernel_sums),
        .i_mask   (mask),
        .i_scaler (scaler),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    tconv_cfg_regs u_cfg (
        .clk         (clk),
        .rst         (rst),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .o_scaler    (scaler),
        .o_mask      (mask)
    );

endmodule

/* verification/tconv_checker.sv */
// Credit counter assertions

`timescale 1ns/1ps

`include "tconv_params.svh"

module tconv_checker
    import tconv_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        i_ready,
    input logic        i_credit_return,
    input credit_cnt_t i_credits
);

    localparam credit_cnt_t FULL = credit_cnt_t'(`TCONV_CREDITS);

    a_credit_limit: assert property (@(posedge clk) disable iff (rst) i_credits <= FULL)
        else $error("credit count above the downstream buffer size");

    // with no slot left and none coming back, a waiting beat stays out
    a_hold_empty: assert property (@(posedge clk) disable iff (rst)
        (i_credits == '0 && !i_credit_return) |=> (i_credits == '0))
        else $error("beat accepted with no credits");

    // downstream cannot hand back a slot it never had
    a_return_full: assert property (@(posedge clk) disable iff (rst)
        (i_credits == FULL) |-> !i_credit_return)
        else $error("credit returned while the count is full");

endmodule

bind tconv_credit_ctrl tconv_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .i_ready         (o_ready),
    .i_credit_return (i_credit_return),
    .i_credits       (o_credits)
);

/* verification/tconv_tb.sv */
// Accumulation back end testbench

`timescale 1ns/1ps

`include "tconv_params.svh"

module tconv_tb
    import tconv_pkg::*;
();

    localparam int FW         = `TCONV_FEATURE_WIDTH;
    localparam int N_TERMS    = `TCONV_KERNEL_SIZE * `TCONV_KERNEL_SIZE;
    localparam int N_PRODUCTS = `TCONV_TN * N_TERMS;
    // about 400 cycles of tests in all, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    typedef logic [N_PRODUCTS*FW-1:0] terms_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       i_valid;
    terms_t     i_terms;
    logic       o_ready;
    logic       i_credit_return;
    logic       o_valid;
    scaled_t    o_result;
    logic       i_cfg_we;
    cfg_addr_t  i_cfg_addr;
    scaler_t    i_cfg_wdata;
    scaler_t    o_cfg_rdata;
    integer     seed = 32'hc6ba_8151;
    int         cycle = 0;
    int         return_pending = 0;
    logic       auto_return = 1'b1;
    scaler_t    model_scaler = 16'd1;
    chan_mask_t model_mask = '1;
    scaled_t    exp_q[$];
    int         accept_q[$];

    tconv_accum_top u_dut (.*);

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_result(input scaled_t got, input scaled_t exp);
        if (got !== exp)
            fail_run($sformatf("ERR %0t: result %h, expected %h", $time, got, exp));
    endtask

    task automatic check_cfg(input scaler_t got, input scaler_t exp, input cfg_addr_t addr);
        if (got !== exp)
            fail_run($sformatf("ERR %0t: register %0d reads %h, expected %h",
                               $time, addr, got, exp));
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // model sums wrap at 16 bits and the scaled product is 32 bits
    function automatic scaled_t model_result(input terms_t terms, input scaler_t scl,
                                             input chan_mask_t msk);
        feature_t kernel_sum;
        feature_t total;
        total = '0;
        for (int c = 0; c < `TCONV_TN; c++) begin
            kernel_sum = '0;
            for (int k = 0; k < N_TERMS; k++) begin
                kernel_sum = kernel_sum + terms[(c * N_TERMS + k) * FW +: FW];
            end
            if (msk[c])
                total = total + kernel_sum;
        end
        return scaled_t'(total) * scaled_t'(scl);
    endfunction

    function automatic terms_t random_terms();
        terms_t t;
        for (int i = 0; i < N_PRODUCTS; i++) begin
            t[i*FW +: FW] = $random(seed);
        end
        return t;
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
            fail_run("timeout: the run did not finish within the cycle limit");
    end

    // downstream hands back one credit per pulse
    always @(posedge clk) begin
        #1;
        i_credit_return = (return_pending > 0);
        if (return_pending > 0)
            return_pending--;
    end

    // sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!rst && i_valid && o_ready) begin
            exp_q.push_back(model_result(i_terms, model_scaler, model_mask));
            accept_q.push_back(cycle);
        end
        if (!rst && o_valid) begin
            if (exp_q.size() == 0)
                fail_run("a result arrived with no beat outstanding");
            check_result(o_result, exp_q.pop_front());
            if (cycle - accept_q.pop_front() != 6)
                fail_run("a result did not arrive 6 cycles after its beat was accepted");
            if (auto_return)
                return_pending++;
        end
    end

    task automatic send_beat(input terms_t terms);
        @(posedge clk);
        #1;
        i_valid = 1'b1;
        i_terms = terms;
        do
            @(negedge clk);
        while (!o_ready);
    endtask

    // drop valid after the last accept, then let results and credits drain
    task automatic wait_idle();
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        while (exp_q.size() != 0 || return_pending != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
        check_ready(o_ready, 1'b1, "o_ready when idle");
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input scaler_t data);
        @(posedge clk);
        #1;
        i_cfg_we    = 1'b1;
        i_cfg_addr  = addr;
        i_cfg_wdata = data;
        @(posedge clk);
        #1;
        i_cfg_we = 1'b0;
        if (addr == CFG_ADDR_SCALER)
            model_scaler = data;
        else
            model_mask = chan_mask_t'(data);
    endtask

    task automatic read_cfg(input cfg_addr_t addr, input scaler_t exp);
        @(posedge clk);
        #1;
        i_cfg_addr = addr;
        @(negedge clk);
        check_cfg(o_cfg_rdata, exp, addr);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_ready(o_ready, 1'b1, "o_ready after reset");
        check_ready(o_valid, 1'b0, "o_valid after reset");
        read_cfg(CFG_ADDR_SCALER, 16'd1);
        read_cfg(CFG_ADDR_MASK, 16'd15);
    endtask

    task automatic test_known_beats();
        terms_t ones;
        terms_t ramp;
        for (int i = 0; i < N_PRODUCTS; i++) begin
            ones[i*FW +: FW] = feature_t'(1);
            ramp[i*FW +: FW] = feature_t'(i + 1);
        end
        send_beat(ones);
        wait_idle();
        send_beat(ramp);
        wait_idle();
    endtask

    // random 16-bit products overflow the kernel sums in nearly every beat
    task automatic test_random_config();
        for (int n = 0; n < 12; n++) begin
            write_cfg(CFG_ADDR_SCALER, scaler_t'($random(seed)));
            write_cfg(CFG_ADDR_MASK, scaler_t'($random(seed)));
            read_cfg(CFG_ADDR_SCALER, model_scaler);
            read_cfg(CFG_ADDR_MASK, scaler_t'(model_mask));
            send_beat(random_terms());
            wait_idle();
        end
    endtask

    task automatic test_back_pressure();
        auto_return = 1'b0;
        for (int n = 0; n < `TCONV_CREDITS; n++) begin
            send_beat(random_terms());
        end
        // a fifth beat waits while the first four results drain
        @(posedge clk);
        #1;
        i_terms = random_terms();
        repeat (12) begin
            @(negedge clk);
            check_ready(o_ready, 1'b0, "o_ready with no credits left");
        end
        if (exp_q.size() != 0)
            fail_run("results of the back-pressured beats did not all arrive");
        return_pending++;
        do
            @(negedge clk);
        while (!o_ready);
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        @(negedge clk);
        check_ready(o_ready, 1'b0, "o_ready after the reopened beat");
        // three slots still owed, the fifth result returns its own
        auto_return = 1'b1;
        return_pending += 3;
        wait_idle();
    endtask

    task automatic test_streaming();
        for (int n = 0; n < 16; n++) begin
            send_beat(random_terms());
        end
        wait_idle();
    endtask

    initial begin
        rst             = 1'b1;
        i_valid         = 1'b0;
        i_terms         = '0;
        i_credit_return = 1'b0;
        i_cfg_we        = 1'b0;
        i_cfg_addr      = CFG_ADDR_SCALER;
        i_cfg_wdata     = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_known_beats();
        test_random_config();
        test_back_pressure();
        test_streaming();
        if (exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run("results were still outstanding at the end of the run");
        end
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/tconv_pkg.sv
rtl/kernel_adder_tree.sv
rtl/channel_scale_stage.sv
rtl/tconv_cfg_regs.sv
rtl/tconv_credit_ctrl.sv
rtl/tconv_accum_top.sv
verification/tconv_checker.sv
verification/tconv_tb.sv
